/* flist.f */
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/sram_sp.sv
logic/cache_arrays.sv
logic/refill_unit.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/cache_tb.sv

/* test/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb;

	localparam int OPS = 17;
	localparam int STEP_LIMIT = 40;

	logic clk;
	logic rst;
	logic req_valid;
	cache_ctrl_pkg::req_op_t req_op;
	logic [cache_geom_pkg::ADDR_W-1:0] req_addr;
	logic [cache_geom_pkg::STRB_W-1:0] wstrb;
	logic [cache_geom_pkg::WORD_W-1:0] wdata;
	logic addr_ok;
	logic data_ok;
	logic [cache_geom_pkg::WORD_W-1:0] rdata;
	logic waxi_valid;
	logic [cache_geom_pkg::ADDR_W-1:0] waxi_addr;
	logic [cache_geom_pkg::LINE_W-1:0] waxi_data;
	logic waxi_ready;
	logic raxi_valid;
	logic [cache_geom_pkg::ADDR_W-1:0] raxi_addr;
	logic raxi_dvalid;
	logic raxi_dlast;
	logic [cache_geom_pkg::WORD_W-1:0] raxi_data;

	int errors;
	bit slow_mem;
	bit raxi_seen;
	logic [31:0] raxi_addr_seen;
	bit wb_seen;
	bit wb_expected;
	logic [31:0] wb_addr_seen;
	logic [127:0] wb_data_seen;

	// memory contents as the DUT wrote them, and as the model expects them
	logic [127:0] mem_lines [logic [31:0]];
	logic [127:0] ref_mem [logic [31:0]];

	// reference cache state
	logic [cache_geom_pkg::TAG_W-1:0] m_tag [cache_geom_pkg::WAYS][cache_geom_pkg::SETS];
	logic [127:0] m_data [cache_geom_pkg::WAYS][cache_geom_pkg::SETS];
	bit m_valid [cache_geom_pkg::WAYS][cache_geom_pkg::SETS];
	bit m_dirty [cache_geom_pkg::WAYS][cache_geom_pkg::SETS];
	bit m_rr;

	// expected response of the access in flight
	bit exp_hit;
	bit exp_wb;
	logic [63:0] exp_rdata;
	logic [31:0] exp_wb_addr;
	logic [127:0] exp_wb_data;

	cache_top dut (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// untouched memory ties both words to the line address
	function automatic logic [127:0] line_pattern(input logic [31:0] line_addr);
		logic [63:0] w0;
		logic [63:0] w1;
		w0 = {line_addr ^ 32'hc3c3_3c3c, line_addr};
		w1 = {~line_addr, line_addr | 32'h8};
		return {w1, w0};
	endfunction

	function automatic logic [63:0] byte_merge(input logic [63:0] old_w,
		input logic [63:0] new_w, input logic [7:0] strb);
		logic [63:0] mask;
		for (int i = 0; i < 8; i++) begin
			mask[i*8 +: 8] = {8{strb[i]}};
		end
		return (new_w & mask) | (old_w & ~mask);
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// mirrors one access and predicts hit, write-back and read data
	task automatic model_access(input cache_ctrl_pkg::req_op_t op, input logic [31:0] addr,
		input logic [7:0] strb, input logic [63:0] data);
		logic [23:0] tag;
		logic [3:0] set;
		logic [31:0] line_addr;
		logic [127:0] line;
		int word;
		int way;
		tag = addr[31:8];
		set = addr[7:4];
		word = addr[3];
		line_addr = {addr[31:4], 4'h0};
		exp_hit = 1'b0;
		exp_wb = 1'b0;
		way = 0;
		for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
			if (m_valid[w][set] && m_tag[w][set] == tag) begin
				exp_hit = 1'b1;
				way = w;
			end
		end
		if (!exp_hit) begin
			if (!m_valid[0][set]) way = 0;
			else if (!m_valid[1][set]) way = 1;
			else way = m_rr;
			if (m_valid[way][set] && m_dirty[way][set]) begin
				exp_wb = 1'b1;
				exp_wb_addr = {m_tag[way][set], set, 4'h0};
				exp_wb_data = m_data[way][set];
				ref_mem[exp_wb_addr] = exp_wb_data;
			end
			line = ref_mem.exists(line_addr) ? ref_mem[line_addr] : line_pattern(line_addr);
			m_data[way][set] = line;
			m_tag[way][set] = tag;
			m_valid[way][set] = 1'b1;
			m_dirty[way][set] = 1'b0;
			m_rr = !m_rr;
		end
		line = m_data[way][set];
		exp_rdata = line[word*64 +: 64];
		if (op == cache_ctrl_pkg::OP_WRITE) begin
			line[word*64 +: 64] = byte_merge(exp_rdata, data, strb);
			m_data[way][set] = line;
			m_dirty[way][set] = 1'b1;
		end
	endtask

	// starts and ends on a falling edge with addr_ok high
	task automatic run_access(input cache_ctrl_pkg::req_op_t op, input logic [31:0] addr,
		input logic [7:0] strb, input logic [63:0] data);
		int cycles;
		model_access(op, addr, strb, data);
		raxi_seen = 1'b0;
		wb_seen = 1'b0;
		wb_expected = exp_wb;
		cycles = 0;
		while (!addr_ok && cycles < STEP_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		check_true(addr_ok, "cache never became ready for a request");
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		wstrb = strb;
		wdata = data;
		@(negedge clk);
		req_valid = 1'b0;
		cycles = 1;
		while (!data_ok && cycles < STEP_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		check_true(data_ok, "data_ok never came for the request");
		if (op == cache_ctrl_pkg::OP_READ) check_value("rdata", exp_rdata, rdata);
		if (exp_hit) begin
			check_true(cycles == 1, "hit did not answer in the cycle after acceptance");
			check_true(!raxi_seen, "refill was requested on a hit");
		end else begin
			check_true(raxi_seen, "miss did not request a refill");
			check_value("raxi_addr", {addr[31:4], 4'h0}, raxi_addr_seen);
		end
		check_true(wb_seen == exp_wb, "write-back happened where none was due, or was missing");
		if (exp_wb && wb_seen) begin
			check_value("waxi_addr", exp_wb_addr, wb_addr_seen);
			check_value("waxi_data", exp_wb_data, wb_data_seen);
		end
		@(negedge clk);
		check_true(!data_ok, "data_ok stayed high for more than one cycle");
		// write hit spends one more cycle committing the word
		if (exp_hit && op == cache_ctrl_pkg::OP_WRITE) begin
			check_true(!addr_ok, "addr_ok came back too early after a write hit");
			@(negedge clk);
		end
		check_true(addr_ok, "addr_ok did not return after the request");
	endtask

	task automatic do_read(input logic [31:0] addr);
		run_access(cache_ctrl_pkg::OP_READ, addr, '0, '0);
	endtask

	task automatic do_write(input logic [31:0] addr, input logic [7:0] strb,
		input logic [63:0] data);
		run_access(cache_ctrl_pkg::OP_WRITE, addr, strb, data);
	endtask

	task automatic reset_state_and_first_read();
		check_value("addr_ok", 1'b1, addr_ok);
		check_value("data_ok", 1'b0, data_ok);
		check_value("waxi_valid", 1'b0, waxi_valid);
		check_value("raxi_valid", 1'b0, raxi_valid);
		do_read(32'h1234_5610);
	endtask

	task automatic read_hits();
		do_read(32'h1234_5610);
		do_read(32'h1234_5618);
	endtask

	task automatic write_hit_merge();
		do_write(32'h1234_5618, 8'h5a, 64'h1122_3344_5566_7788);
		do_read(32'h1234_5618);
	endtask

	task automatic write_miss_allocate();
		do_write(32'h0bad_c028, 8'hf0, 64'hdead_beef_cafe_f00d);
		do_read(32'h0bad_c020);
		do_read(32'h0bad_c028);
	endtask

	// three tags share set 1 and both dirty lines get evicted
	task automatic dirty_eviction();
		do_write(32'h5555_5510, 8'h0f, 64'h0123_4567_89ab_cdef);
		do_read(32'h7777_7710);
		do_read(32'h5555_5510);
		do_read(32'h1234_5618);
	endtask

	task automatic back_pressure();
		logic [63:0] d;
		slow_mem = 1'b1;
		d = {$urandom, $urandom};
		do_write(32'h00aa_0050, 8'hff, d);
		d = {$urandom, $urandom};
		do_write(32'h00bb_0058, 8'h3c, d);
		d = {$urandom, $urandom};
		do_write(32'h00cc_0050, 8'h81, d);
		do_read(32'h00aa_0050);
		do_read(32'h00cc_0050);
		slow_mem = 1'b0;
	endtask

	// refill must wait for the write-back handshake
	always @(negedge clk) begin
		if (!rst) begin
			if (raxi_valid) begin
				raxi_seen = 1'b1;
				raxi_addr_seen = raxi_addr;
				check_true(!(wb_expected && !wb_seen),
					"refill requested while a write-back was still pending");
			end
			check_true(!(raxi_valid && waxi_valid), "raxi_valid and waxi_valid high together");
		end
	end

	initial begin : memory_model
		logic [31:0] line_addr;
		logic [127:0] line;
		int wait_cycles;
		forever begin
			@(negedge clk);
			if (!rst && waxi_valid) begin
				wait_cycles = slow_mem ? 3 : $urandom_range(3, 0);
				repeat (wait_cycles) @(negedge clk);
				waxi_ready = 1'b1;
				wb_seen = 1'b1;
				wb_addr_seen = waxi_addr;
				wb_data_seen = waxi_data;
				mem_lines[waxi_addr] = waxi_data;
				@(negedge clk);
				waxi_ready = 1'b0;
			end else if (!rst && raxi_valid) begin
				line_addr = raxi_addr;
				line = mem_lines.exists(line_addr) ? mem_lines[line_addr] : line_pattern(line_addr);
				for (int b = 0; b < 2; b++) begin
					wait_cycles = slow_mem ? 2 : $urandom_range(2, 0);
					repeat (wait_cycles) @(negedge clk);
					raxi_dvalid = 1'b1;
					raxi_data = line[b*64 +: 64];
					raxi_dlast = (b == 1);
					@(negedge clk);
					raxi_dvalid = 1'b0;
					raxi_dlast = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (OPS * STEP_LIMIT) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", OPS * STEP_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		void'($urandom(75874));
		slow_mem = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_op = cache_ctrl_pkg::OP_READ;
		req_addr = '0;
		wstrb = '0;
		wdata = '0;
		waxi_ready = 1'b0;
		raxi_dvalid = 1'b0;
		raxi_dlast = 1'b0;
		raxi_data = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		reset_state_and_first_read();
		read_hits();
		write_hit_merge();
		write_miss_allocate();
		dirty_eviction();
		back_pressure();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ns

module cache_top (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              req_valid,
	input  cache_ctrl_pkg::req_op_t           req_op,
	input  logic [cache_geom_pkg::ADDR_W-1:0] req_addr,
	input  logic [cache_geom_pkg::STRB_W-1:0] wstrb,
	input  logic [cache_geom_pkg::WORD_W-1:0] wdata,
	output logic                              addr_ok,
	output logic                              data_ok,
	output logic [cache_geom_pkg::WORD_W-1:0] rdata,
	output logic                              waxi_valid,
	output logic [cache_geom_pkg::ADDR_W-1:0] waxi_addr,
	output logic [cache_geom_pkg::LINE_W-1:0] waxi_data,
	input  logic                              waxi_ready,
	output logic                              raxi_valid,
	output logic [cache_geom_pkg::ADDR_W-1:0] raxi_addr,
	input  logic                              raxi_dvalid,
	input  logic                              raxi_dlast,
	input  logic [cache_geom_pkg::WORD_W-1:0] raxi_data
);

	logic rd_en, word_we, fill_we, fill_dirty, set_dirty, victim_dirty;
	logic [cache_geom_pkg::INDEX_W-1:0] rd_index, wr_index;
	logic [cache_geom_pkg::TAG_W-1:0] lookup_tag, victim_tag;
	logic [cache_geom_pkg::WORD_SEL_W-1:0] lookup_word, word_sel, req_word, beat_word;
	logic [cache_geom_pkg::WAYS-1:0] way_hit, way_valid;
	logic [cache_geom_pkg::WORD_W-1:0] hit_word, word_din, beat_data, miss_rdata, buf_wdata;
	logic [$clog2(cache_geom_pkg::WAYS)-1:0] victim_way, wr_way;
	logic [cache_geom_pkg::LINE_W-1:0] victim_block;
	logic [cache_geom_pkg::STRB_W-1:0] buf_wstrb;
	logic refill_active, beat_we, fill_done;
	cache_ctrl_pkg::req_op_t buf_op;

	cache_ctrl u_ctrl (
		.clk, .rst,
		.req_valid, .req_op, .req_addr, .wstrb, .wdata,
		.addr_ok, .data_ok, .rdata,
		.rd_en, .rd_index, .lookup_tag, .lookup_word,
		.way_hit, .hit_word, .way_valid,
		.victim_way, .victim_tag, .victim_dirty, .victim_block,
		.wr_way, .wr_index, .word_we, .word_sel, .word_din,
		.fill_we, .fill_dirty, .set_dirty,
		.refill_active, .beat_we, .beat_word, .beat_data, .fill_done, .miss_rdata,
		.req_word, .buf_op, .buf_wstrb, .buf_wdata,
		.waxi_valid, .waxi_addr, .waxi_data, .waxi_ready,
		.raxi_valid, .raxi_addr
	);

	cache_arrays u_arrays (
		.clk, .rst,
		.rd_en, .rd_index, .lookup_tag, .lookup_word,
		.way_hit, .hit_word, .way_valid,
		.victim_way, .victim_tag, .victim_dirty, .victim_block,
		.wr_way, .wr_index, .word_we, .word_sel, .word_din,
		.fill_we, .fill_dirty, .set_dirty
	);

	// write data for a write miss comes from the request buffer
	refill_unit u_refill (
		.clk, .rst,
		.active(refill_active),
		.raxi_dvalid, .raxi_dlast, .raxi_data,
		.req_op(buf_op),
		.req_word,
		.wstrb(buf_wstrb),
		.wdata(buf_wdata),
		.beat_we, .beat_word, .beat_data, .fill_done, .miss_rdata
	);

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/1ns

module cache_ctrl (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    req_valid,
	input  cache_ctrl_pkg::req_op_t                 req_op,
	input  logic [cache_geom_pkg::ADDR_W-1:0]       req_addr,
	input  logic [cache_geom_pkg::STRB_W-1:0]       wstrb,
	input  logic [cache_geom_pkg::WORD_W-1:0]       wdata,
	output logic                                    addr_ok,
	output logic                                    data_ok,
	output logic [cache_geom_pkg::WORD_W-1:0]       rdata,
	output logic                                    rd_en,
	output logic [cache_geom_pkg::INDEX_W-1:0]      rd_index,
	output logic [cache_geom_pkg::TAG_W-1:0]        lookup_tag,
	output logic [cache_geom_pkg::WORD_SEL_W-1:0]   lookup_word,
	input  logic [cache_geom_pkg::WAYS-1:0]         way_hit,
	input  logic [cache_geom_pkg::WORD_W-1:0]       hit_word,
	input  logic [cache_geom_pkg::WAYS-1:0]         way_valid,
	output logic [$clog2(cache_geom_pkg::WAYS)-1:0] victim_way,
	input  logic [cache_geom_pkg::TAG_W-1:0]        victim_tag,
	input  logic                                    victim_dirty,
	input  logic [cache_geom_pkg::LINE_W-1:0]       victim_block,
	output logic [$clog2(cache_geom_pkg::WAYS)-1:0] wr_way,
	output logic [cache_geom_pkg::INDEX_W-1:0]      wr_index,
	output logic                                    word_we,
	output logic [cache_geom_pkg::WORD_SEL_W-1:0]   word_sel,
	output logic [cache_geom_pkg::WORD_W-1:0]       word_din,
	output logic                                    fill_we,
	output logic                                    fill_dirty,
	output logic                                    set_dirty,
	output logic                                    refill_active,
	input  logic                                    beat_we,
	input  logic [cache_geom_pkg::WORD_SEL_W-1:0]   beat_word,
	input  logic [cache_geom_pkg::WORD_W-1:0]       beat_data,
	input  logic                                    fill_done,
	input  logic [cache_geom_pkg::WORD_W-1:0]       miss_rdata,
	output logic [cache_geom_pkg::WORD_SEL_W-1:0]   req_word,
	output cache_ctrl_pkg::req_op_t                 buf_op,
	output logic [cache_geom_pkg::STRB_W-1:0]       buf_wstrb,
	output logic [cache_geom_pkg::WORD_W-1:0]       buf_wdata,
	output logic                                    waxi_valid,
	output logic [cache_geom_pkg::ADDR_W-1:0]       waxi_addr,
	output logic [cache_geom_pkg::LINE_W-1:0]       waxi_data,
	input  logic                                    waxi_ready,
	output logic                                    raxi_valid,
	output logic [cache_geom_pkg::ADDR_W-1:0]       raxi_addr
);

	cache_ctrl_pkg::ctrl_state_t state, state_n;

	logic [cache_geom_pkg::TAG_W-1:0] buf_tag;
	logic [cache_geom_pkg::INDEX_W-1:0] buf_index;
	logic [$clog2(cache_geom_pkg::WAYS)-1:0] hit_way_q, miss_way, rr_ptr;
	logic [cache_geom_pkg::WORD_W-1:0] merged_q;
	logic [cache_geom_pkg::TAG_W-1:0] miss_tag;
	logic miss_dirty;
	logic [cache_geom_pkg::LINE_W-1:0] miss_block;
	logic hit;

	assign hit = |way_hit;

	always_comb begin
		state_n = state;
		case (state)
			cache_ctrl_pkg::ST_IDLE: if (req_valid) state_n = cache_ctrl_pkg::ST_LOOKUP;
			cache_ctrl_pkg::ST_LOOKUP: begin
				if (!hit) begin
					state_n = cache_ctrl_pkg::ST_MISS;
				end else if (buf_op == cache_ctrl_pkg::OP_WRITE) begin
					state_n = cache_ctrl_pkg::ST_WRITE;
				end else begin
					state_n = cache_ctrl_pkg::ST_IDLE;
				end
			end
			cache_ctrl_pkg::ST_WRITE: state_n = cache_ctrl_pkg::ST_IDLE;
			// clean victim skips the write-back
			cache_ctrl_pkg::ST_MISS: begin
				if (!miss_dirty || waxi_ready) state_n = cache_ctrl_pkg::ST_REFILL;
			end
			cache_ctrl_pkg::ST_REFILL: if (fill_done) state_n = cache_ctrl_pkg::ST_DONE;
			default: state_n = cache_ctrl_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_ctrl_pkg::ST_IDLE;
			rr_ptr <= '0;
		end else begin
			state <= state_n;
			if (fill_done) rr_ptr <= rr_ptr + 1'b1;
		end
	end

	// request buffer
	always_ff @(posedge clk) begin
		if (addr_ok && req_valid) begin
			buf_op <= req_op;
			buf_tag <= req_addr[cache_geom_pkg::TAG_LSB +: cache_geom_pkg::TAG_W];
			buf_index <= req_addr[cache_geom_pkg::INDEX_LSB +: cache_geom_pkg::INDEX_W];
			req_word <= req_addr[cache_geom_pkg::WORD_LSB +: cache_geom_pkg::WORD_SEL_W];
			buf_wstrb <= wstrb;
			buf_wdata <= wdata;
		end
	end

	// invalid way first, else round robin
	always_comb begin
		if (!way_valid[0]) victim_way = 1'b0;
		else if (!way_valid[1]) victim_way = 1'b1;
		else victim_way = rr_ptr;
	end

	// hit merge and miss buffer are both taken in lookup
	always_ff @(posedge clk) begin
		if (state == cache_ctrl_pkg::ST_LOOKUP) begin
			hit_way_q <= way_hit[1];
			merged_q <= cache_geom_pkg::strb_merge(hit_word, buf_wdata, buf_wstrb);
			if (!hit) begin
				miss_way <= victim_way;
				miss_tag <= victim_tag;
				miss_dirty <= victim_dirty;
				miss_block <= victim_block;
			end
		end
	end

	assign addr_ok = state == cache_ctrl_pkg::ST_IDLE;
	assign data_ok = (state == cache_ctrl_pkg::ST_LOOKUP && hit) ||
		state == cache_ctrl_pkg::ST_DONE;
	assign rdata = (state == cache_ctrl_pkg::ST_LOOKUP) ? hit_word : miss_rdata;

	assign rd_en = addr_ok && req_valid;
	assign rd_index = req_addr[cache_geom_pkg::INDEX_LSB +: cache_geom_pkg::INDEX_W];
	assign lookup_tag = buf_tag;
	assign lookup_word = req_word;

	// bank writes come from a write-hit commit or a refill beat
	assign wr_way = (state == cache_ctrl_pkg::ST_WRITE) ? hit_way_q : miss_way;
	assign wr_index = buf_index;
	assign word_we = state == cache_ctrl_pkg::ST_WRITE || beat_we;
	assign word_sel = (state == cache_ctrl_pkg::ST_WRITE) ? req_word : beat_word;
	assign word_din = (state == cache_ctrl_pkg::ST_WRITE) ? merged_q : beat_data;
	assign set_dirty = state == cache_ctrl_pkg::ST_WRITE;
	assign fill_we = fill_done;
	assign fill_dirty = buf_op == cache_ctrl_pkg::OP_WRITE;

	assign refill_active = state == cache_ctrl_pkg::ST_REFILL;
	assign raxi_valid = refill_active;
	assign raxi_addr = {buf_tag, buf_index, {cache_geom_pkg::OFFSET_W{1'b0}}};

	assign waxi_valid = state == cache_ctrl_pkg::ST_MISS && miss_dirty;
	assign waxi_addr = {miss_tag, buf_index, {cache_geom_pkg::OFFSET_W{1'b0}}};
	assign waxi_data = miss_block;

	a_ok_excl: assert property (@(posedge clk) disable iff (rst) !(addr_ok && data_ok));

	a_waxi_hold: assert property (@(posedge clk) disable iff (rst)
		waxi_valid && !waxi_ready |=> waxi_valid && $stable(waxi_addr) && $stable(waxi_data));

endmodule

/* logic/refill_unit.sv */
`timescale 1ns/1ns

module refill_unit (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  active,
	input  logic                                  raxi_dvalid,
	input  logic                                  raxi_dlast,
	input  logic [cache_geom_pkg::WORD_W-1:0]     raxi_data,
	input  cache_ctrl_pkg::req_op_t               req_op,
	input  logic [cache_geom_pkg::WORD_SEL_W-1:0] req_word,
	input  logic [cache_geom_pkg::STRB_W-1:0]     wstrb,
	input  logic [cache_geom_pkg::WORD_W-1:0]     wdata,
	output logic                                  beat_we,
	output logic [cache_geom_pkg::WORD_SEL_W-1:0] beat_word,
	output logic [cache_geom_pkg::WORD_W-1:0]     beat_data,
	output logic                                  fill_done,
	output logic [cache_geom_pkg::WORD_W-1:0]     miss_rdata
);

	logic [cache_geom_pkg::WORD_SEL_W-1:0] beat_cnt;
	logic req_beat;

	// beat counter clears outside the refill
	always_ff @(posedge clk) begin
		if (rst || !active) begin
			beat_cnt <= '0;
		end else if (raxi_dvalid) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign beat_we = active && raxi_dvalid;
	assign beat_word = beat_cnt;
	assign fill_done = beat_we && raxi_dlast;
	assign req_beat = beat_we && (beat_cnt == req_word);

	// write miss lands its bytes on top of the memory word
	assign beat_data = (req_op == cache_ctrl_pkg::OP_WRITE && beat_cnt == req_word) ?
		cache_geom_pkg::strb_merge(raxi_data, wdata, wstrb) : raxi_data;

	// raw word for a read miss
	always_ff @(posedge clk) begin
		if (req_beat) begin
			miss_rdata <= raxi_data;
		end
	end

	a_last_beat: assert property (@(posedge clk) disable iff (rst)
		beat_we && raxi_dlast |-> beat_cnt == cache_geom_pkg::WORDS_PER_LINE - 1);

endmodule

/* logic/cache_arrays.sv */
`timescale 1ns/1ns

module cache_arrays (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   rd_en,
	input  logic [cache_geom_pkg::INDEX_W-1:0]     rd_index,
	input  logic [cache_geom_pkg::TAG_W-1:0]       lookup_tag,
	input  logic [cache_geom_pkg::WORD_SEL_W-1:0]  lookup_word,
	output logic [cache_geom_pkg::WAYS-1:0]        way_hit,
	output logic [cache_geom_pkg::WORD_W-1:0]      hit_word,
	output logic [cache_geom_pkg::WAYS-1:0]        way_valid,
	input  logic [$clog2(cache_geom_pkg::WAYS)-1:0] victim_way,
	output logic [cache_geom_pkg::TAG_W-1:0]       victim_tag,
	output logic                                   victim_dirty,
	output logic [cache_geom_pkg::LINE_W-1:0]      victim_block,
	input  logic [$clog2(cache_geom_pkg::WAYS)-1:0] wr_way,
	input  logic [cache_geom_pkg::INDEX_W-1:0]     wr_index,
	input  logic                                   word_we,
	input  logic [cache_geom_pkg::WORD_SEL_W-1:0]  word_sel,
	input  logic [cache_geom_pkg::WORD_W-1:0]      word_din,
	input  logic                                   fill_we,
	input  logic                                   fill_dirty,
	input  logic                                   set_dirty
);

	logic [cache_geom_pkg::SETS-1:0] valid_q [cache_geom_pkg::WAYS];
	logic [cache_geom_pkg::SETS-1:0] dirty_q [cache_geom_pkg::WAYS];
	logic [cache_geom_pkg::INDEX_W-1:0] idx_q;
	logic [cache_geom_pkg::INDEX_W-1:0] bank_index;
	logic [cache_geom_pkg::TAG_W-1:0] tag_dout [cache_geom_pkg::WAYS];
	logic [cache_geom_pkg::WORD_W-1:0] data_dout [cache_geom_pkg::WAYS][cache_geom_pkg::WORDS_PER_LINE];

	// writes take the bank address away from the lookup
	assign bank_index = (word_we || fill_we) ? wr_index : rd_index;

	// set whose tags and data sit on the bank outputs
	always_ff @(posedge clk) begin
		if (rst) begin
			idx_q <= '0;
		end else if (rd_en) begin
			idx_q <= rd_index;
		end
	end

	for (genvar w = 0; w < cache_geom_pkg::WAYS; w++) begin : g_way
		logic tag_we;

		assign tag_we = fill_we && (wr_way == w);

		sram_sp #(
			.WIDTH(cache_geom_pkg::TAG_W),
			.DEPTH(cache_geom_pkg::SETS)
		) u_tag (
			.clk(clk),
			.en(rd_en || tag_we),
			.we(tag_we),
			.addr(bank_index),
			.din(lookup_tag),
			.dout(tag_dout[w])
		);

		// one bank per word of the line
		for (genvar b = 0; b < cache_geom_pkg::WORDS_PER_LINE; b++) begin : g_bank
			logic data_we;

			assign data_we = word_we && (wr_way == w) && (word_sel == b);

			sram_sp #(
				.WIDTH(cache_geom_pkg::WORD_W),
				.DEPTH(cache_geom_pkg::SETS)
			) u_data (
				.clk(clk),
				.en(rd_en || data_we),
				.we(data_we),
				.addr(bank_index),
				.din(word_din),
				.dout(data_dout[w][b])
			);
		end

		assign way_valid[w] = valid_q[w][idx_q];
		assign way_hit[w] = way_valid[w] && (tag_dout[w] == lookup_tag);
	end

	always_comb begin
		hit_word = '0;
		for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
			if (way_hit[w]) begin
				hit_word = data_dout[w][lookup_word];
			end
		end
	end

	assign victim_tag = tag_dout[victim_way];
	assign victim_dirty = dirty_q[victim_way][idx_q];

	always_comb begin
		for (int b = 0; b < cache_geom_pkg::WORDS_PER_LINE; b++) begin
			victim_block[b*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] =
				data_dout[victim_way][b];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
		end else begin
			if (fill_we) begin
				valid_q[wr_way][wr_index] <= 1'b1;
				dirty_q[wr_way][wr_index] <= fill_dirty;
			end
			if (set_dirty) begin
				dirty_q[wr_way][wr_index] <= 1'b1;
			end
		end
	end

	// a line is never allocated twice in one set
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

/* logic/sram_sp.sv */
`timescale 1ns/1ns

module sram_sp #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         din,
	output logic [WIDTH-1:0]         dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	// write-first, so dout follows a fresh write
	// dout holds while en is low
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
				dout <= din;
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

/* logic/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

	// main controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITE,
		ST_MISS,
		ST_REFILL,
		ST_DONE
	} ctrl_state_t;

	// request opcode from the core
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} req_op_t;

endpackage

/* logic/cache_geom_pkg.sv */
package cache_geom_pkg;

	localparam int ADDR_W = 32;
	localparam int TAG_W = 24;
	localparam int INDEX_W = 4;
	localparam int SETS = 16;
	localparam int WORD_SEL_W = 1;
	localparam int WORDS_PER_LINE = 2;
	localparam int WAYS = 2;
	localparam int WORD_W = 64;
	localparam int STRB_W = 8;
	localparam int LINE_W = 128;

	// address split into tag 31..8, index 7..4 and word select 3
	localparam int OFFSET_W = 4;
	localparam int INDEX_LSB = OFFSET_W;
	localparam int TAG_LSB = INDEX_LSB + INDEX_W;
	localparam int WORD_LSB = OFFSET_W - WORD_SEL_W;

	// new bytes where the strobe is set, old bytes elsewhere
	function automatic logic [WORD_W-1:0] strb_merge(
		input logic [WORD_W-1:0] old_data,
		input logic [WORD_W-1:0] new_data,
		input logic [STRB_W-1:0] strb
	);
		logic [WORD_W-1:0] merged;
		for (int i = 0; i < STRB_W; i++) begin
			merged[i*8 +: 8] = strb[i] ? new_data[i*8 +: 8] : old_data[i*8 +: 8];
		end
		return merged;
	endfunction

endpackage
